//--- design/noc_defs.svh
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

////////////////////
// mesh geometry
////////////////////

// nodes along each axis
`define NOC_X_NODES 4
`define NOC_Y_NODES 4

// coordinate field widths
`define NOC_X_W 2
`define NOC_Y_W 2

////////////////////
// flit and buffer
////////////////////

// kind in the top two bits, rest is route or payload
`define NOC_FLIT_W 8

// entries per input buffer
`define NOC_BUF_DEPTH 4

`endif

//--- design/noc_flit_pkg.sv
`default_nettype none

`include "noc_defs.svh"

package noc_flit_pkg;

   // field widths derived from the flit width
   localparam int FLIT_KIND_W    = 2;
   localparam int FLIT_PAYLOAD_W = `NOC_FLIT_W - FLIT_KIND_W;
   localparam int FLIT_SPARE_W   = `NOC_FLIT_W - FLIT_KIND_W - `NOC_Y_W - `NOC_X_W;

   // flit type in bits 7:6
   typedef enum logic [FLIT_KIND_W-1:0] {
      FLIT_BODY = 2'b00,
      FLIT_TAIL = 2'b01,
      FLIT_HDR  = 2'b10
   } flit_kind_t;

   // one flit word, two decodings
   typedef union packed {
      // header view
      struct packed {
         flit_kind_t              kind;
         logic [FLIT_SPARE_W-1:0] spare;
         logic [`NOC_Y_W-1:0]     dest_y;
         logic [`NOC_X_W-1:0]     dest_x;
      } hdr;
      // body and tail view
      struct packed {
         flit_kind_t                kind;
         logic [FLIT_PAYLOAD_W-1:0] payload;
      } body;
   } flit_u;

endpackage

`default_nettype wire

//--- design/noc_port_pkg.sv
`default_nettype none

package noc_port_pkg;

   // five router ports
   localparam int NUM_PORTS  = 5;
   localparam int PORT_IDX_W = 3;

   ////////////////////
   // port numbering
   ////////////////////

   // also the bit position in a request or grant vector
   typedef enum logic [PORT_IDX_W-1:0] {
      PORT_LOCAL = 3'd0,
      PORT_EAST  = 3'd1,
      PORT_WEST  = 3'd2,
      PORT_SOUTH = 3'd3,
      PORT_NORTH = 3'd4
   } port_idx_t;

   ////////////////////
   // request vectors
   ////////////////////

   // one-hot, one bit per port
   // route requests and arbiter grants both use it
   typedef logic [NUM_PORTS-1:0] port_req_t;

endpackage

`default_nettype wire

//--- design/noc_route_compute.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module noc_route_compute #(
   parameter int X_ADDR = 0,
   parameter int Y_ADDR = 0
) (
   input  wire logic [`NOC_X_W-1:0] dest_x,
   input  wire logic [`NOC_Y_W-1:0] dest_y,
   output noc_port_pkg::port_req_t  route_req
);

   import noc_port_pkg::*;

   // own position, folded into the mesh
   localparam int X_SELF = X_ADDR % `NOC_X_NODES;
   localparam int Y_SELF = Y_ADDR % `NOC_Y_NODES;

   // one extra bit for the sign
   logic signed [`NOC_X_W:0] xdiff;
   logic signed [`NOC_Y_W:0] ydiff;

   assign xdiff = $signed({1'b0, dest_x}) - $signed(X_SELF[`NOC_X_W:0]);
   assign ydiff = $signed({1'b0, dest_y}) - $signed(Y_SELF[`NOC_Y_W:0]);

   ////////////////////
   // xy decision
   ////////////////////

   // x first, then y, then deliver
   always_comb begin
      route_req = '0;
      if (xdiff[`NOC_X_W]) begin
         // destination lies to the west
         route_req[PORT_WEST] = 1'b1;
      end else if (xdiff != '0) begin
         route_req[PORT_EAST] = 1'b1;
      end else if (ydiff[`NOC_Y_W]) begin
         // smaller y is north
         route_req[PORT_NORTH] = 1'b1;
      end else if (ydiff != '0) begin
         route_req[PORT_SOUTH] = 1'b1;
      end else begin
         // arrived
         route_req[PORT_LOCAL] = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- design/noc_input_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module noc_input_port #(
   parameter int X_ADDR = 0,
   parameter int Y_ADDR = 0
) (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   in_valid,
   input  wire logic [`NOC_FLIT_W-1:0] in_flit,
   input  wire logic                   pop,
   output logic                        head_valid,
   output logic [`NOC_FLIT_W-1:0]      head_flit,
   output noc_port_pkg::port_req_t     head_req,
   output logic                        overflow
);

   import noc_port_pkg::*;
   import noc_flit_pkg::*;

   localparam int PTR_W = $clog2(`NOC_BUF_DEPTH);
   localparam int CNT_W = $clog2(`NOC_BUF_DEPTH + 1);

   logic [`NOC_FLIT_W-1:0] mem [`NOC_BUF_DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       count;
   logic                   full;
   logic                   push;
   logic                   do_pop;
   flit_u                  head_u;
   port_req_t              route_req;
   port_req_t              held_req;

   // wrap at depth, depth need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      nxt = (ptr == PTR_W'(`NOC_BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
      return nxt;
   endfunction

   assign full       = (count == CNT_W'(`NOC_BUF_DEPTH));
   assign head_valid = (count != '0);
   // no back-pressure, a full buffer loses the flit
   assign push       = in_valid && !full;
   assign do_pop     = pop && head_valid;

   ////////////////////
   // flit buffer
   ////////////////////

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // sticky until reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         overflow <= 1'b0;
      end else if (in_valid && full) begin
         overflow <= 1'b1;
      end
   end

   ////////////////////
   // route per packet
   ////////////////////

   assign head_flit = mem[rd_ptr];
   assign head_u    = head_flit;

   // decode the head as a header
   noc_route_compute #(
      .X_ADDR (X_ADDR),
      .Y_ADDR (Y_ADDR)
   ) i_route (
      .dest_x    (head_u.hdr.dest_x),
      .dest_y    (head_u.hdr.dest_y),
      .route_req (route_req)
   );

   // header route kept for body and tail
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         held_req <= '0;
      end else if (do_pop) begin
         if (head_u.hdr.kind == FLIT_HDR) begin
            held_req <= route_req;
         end else if (head_u.hdr.kind == FLIT_TAIL) begin
            held_req <= '0;
         end
      end
   end

   // a header asks directly, later flits use the held route
   always_comb begin
      head_req = '0;
      if (head_valid) begin
         head_req = (head_u.hdr.kind == FLIT_HDR) ? route_req : held_req;
      end
   end

endmodule

`default_nettype wire

//--- design/noc_output_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module noc_output_arbiter (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire noc_port_pkg::port_req_t  req,
   input  wire noc_flit_pkg::flit_kind_t head_kind [noc_port_pkg::NUM_PORTS],
   output noc_port_pkg::port_req_t       grant
);

   import noc_port_pkg::*;
   import noc_flit_pkg::*;

   // packet lock
   logic      locked;
   port_idx_t lock_idx;
   // round-robin pointer, last packet winner
   port_idx_t last_idx;
   // this cycle's winner
   port_idx_t win_idx;
   logic      win_found;

   ////////////////////
   // grant
   ////////////////////

   always_comb begin
      logic [PORT_IDX_W-1:0] cand;
      grant     = '0;
      win_idx   = lock_idx;
      win_found = 1'b0;
      cand      = '0;
      if (locked) begin
         // only the owner of the worm may go
         if (req[lock_idx]) begin
            grant[lock_idx] = 1'b1;
            win_found       = 1'b1;
         end
      end else begin
         // search starts one past the last winner
         for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = PORT_IDX_W'((int'(last_idx) + k) % NUM_PORTS);
            if (!win_found && req[cand]) begin
               grant[cand] = 1'b1;
               win_idx     = port_idx_t'(cand);
               win_found   = 1'b1;
            end
         end
      end
   end

   ////////////////////
   // lock and priority
   ////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         locked   <= 1'b0;
         lock_idx <= PORT_LOCAL;
         // east is first after reset
         last_idx <= PORT_LOCAL;
      end else if (win_found) begin
         if (head_kind[win_idx] == FLIT_HDR) begin
            // hold the output for this packet
            locked   <= 1'b1;
            lock_idx <= win_idx;
         end else if (head_kind[win_idx] == FLIT_TAIL) begin
            // worm done, others get a turn
            locked   <= 1'b0;
            last_idx <= win_idx;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/noc_crossbar.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module noc_crossbar (
   input  wire noc_port_pkg::port_req_t grant     [noc_port_pkg::NUM_PORTS],
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic [`NOC_FLIT_W-1:0]  head_flit [noc_port_pkg::NUM_PORTS],
   output logic [noc_port_pkg::NUM_PORTS-1:0] out_valid,
   output logic [`NOC_FLIT_W-1:0]       out_flit  [noc_port_pkg::NUM_PORTS]
);

   import noc_port_pkg::*;

   logic [`NOC_FLIT_W-1:0] sel_flit [NUM_PORTS];

   // grants are one-hot, so an or-mux is enough
   always_comb begin
      for (int o = 0; o < NUM_PORTS; o++) begin
         sel_flit[o] = '0;
         for (int i = 0; i < NUM_PORTS; i++) begin
            if (grant[o][i]) begin
               sel_flit[o] = sel_flit[o] | head_flit[i];
            end
         end
      end
   end

   // valid strobe per output
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= '0;
      end else begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            out_valid[o] <= |grant[o];
         end
      end
   end

   // flit data, loaded only on a grant
   always_ff @(posedge clk) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
         if (|grant[o]) begin
            out_flit[o] <= sel_flit[o];
         end
      end
   end

endmodule

`default_nettype wire

//--- design/noc_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module noc_router #(
   parameter int X_ADDR = 0,
   parameter int Y_ADDR = 0
) (
   input  wire logic                           clk,
   input  wire logic                           rst_n,
   input  wire logic [noc_port_pkg::NUM_PORTS-1:0] in_valid,
   input  wire logic [`NOC_FLIT_W-1:0]         in_flit   [noc_port_pkg::NUM_PORTS],
   output logic [noc_port_pkg::NUM_PORTS-1:0]  out_valid,
   output logic [`NOC_FLIT_W-1:0]              out_flit  [noc_port_pkg::NUM_PORTS],
   output logic [noc_port_pkg::NUM_PORTS-1:0]  overflow
);

   import noc_port_pkg::*;
   import noc_flit_pkg::*;

   // per input port
   logic [NUM_PORTS-1:0]   head_valid;
   logic [`NOC_FLIT_W-1:0] head_flit [NUM_PORTS];
   port_req_t              head_req  [NUM_PORTS];
   flit_kind_t             head_kind [NUM_PORTS];
   logic [NUM_PORTS-1:0]   pop;
   // grants seen from the input side
   port_req_t              grant_in  [NUM_PORTS];

   // per output port, bit i is input i
   port_req_t              arb_req   [NUM_PORTS];
   port_req_t              grant     [NUM_PORTS];

   ////////////////////
   // input ports
   ////////////////////

   for (genvar g = 0; g < NUM_PORTS; g++) begin : g_in
      noc_input_port #(
         .X_ADDR (X_ADDR),
         .Y_ADDR (Y_ADDR)
      ) i_in (
         .clk        (clk),
         .rst_n      (rst_n),
         .in_valid   (in_valid[g]),
         .in_flit    (in_flit[g]),
         .pop        (pop[g]),
         .head_valid (head_valid[g]),
         .head_flit  (head_flit[g]),
         .head_req   (head_req[g]),
         .overflow   (overflow[g])
      );

      // kind field for the arbiters
      assign head_kind[g] = flit_kind_t'(head_flit[g][`NOC_FLIT_W-1 -: FLIT_KIND_W]);
      // at most one output grants an input
      assign pop[g] = |grant_in[g];
   end

   // requests to outputs, grants back to inputs
   for (genvar o = 0; o < NUM_PORTS; o++) begin : g_xpose_o
      for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xpose_i
         assign arb_req[o][i]  = head_valid[i] & head_req[i][o];
         assign grant_in[i][o] = grant[o][i];
      end
   end

   ////////////////////
   // output arbiters
   ////////////////////

   for (genvar g = 0; g < NUM_PORTS; g++) begin : g_arb
      noc_output_arbiter i_arb (
         .clk       (clk),
         .rst_n     (rst_n),
         .req       (arb_req[g]),
         .head_kind (head_kind),
         .grant     (grant[g])
      );
   end

   // switch, one register stage
   noc_crossbar i_xbar (
      .grant     (grant),
      .clk       (clk),
      .rst_n     (rst_n),
      .head_flit (head_flit),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

endmodule

`default_nettype wire

//--- dv/noc_router_props.sv
`timescale 1ns/1ns
`default_nettype none

module noc_router_props (
   input wire logic                                clk,
   input wire logic                                rst_n,
   input wire logic [noc_port_pkg::NUM_PORTS-1:0]  in_valid,
   input wire logic [noc_port_pkg::NUM_PORTS-1:0]  head_valid,
   input wire noc_port_pkg::port_req_t             grant [noc_port_pkg::NUM_PORTS],
   input wire logic [noc_port_pkg::NUM_PORTS-1:0]  out_valid
);

   import noc_port_pkg::*;

   // grants seen from the input side, bit o is output o
   port_req_t in_grant [NUM_PORTS];

   for (genvar o = 0; o < NUM_PORTS; o++) begin : g_xpose_o
      for (genvar i = 0; i < NUM_PORTS; i++) begin : g_xpose_i
         assign in_grant[i][o] = grant[o][i];
      end
   end

   ////////////////////
   // per output
   ////////////////////

   for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
      // one winner per output and cycle
      a_one_winner: assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(grant[o]))
         else $error("output %0d granted several inputs at once", o);
   end

   ////////////////////
   // per input
   ////////////////////

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
      // a worm holds one route, so one output at most
      a_one_output: assert property (@(posedge clk) disable iff (!rst_n)
         $onehot0(in_grant[i]))
         else $error("input %0d popped by several outputs", i);

      // lone flit into an idle router
      // write edge, then grant edge, then the strobe is seen
      a_lone_latency: assert property (@(posedge clk) disable iff (!rst_n)
         (in_valid == NUM_PORTS'(1 << i) && head_valid == '0) |-> ##2 (|out_valid))
         else $error("input %0d lone flit did not leave two cycles after its strobe", i);
   end

endmodule

bind noc_router noc_router_props i_props (
   .clk        (clk),
   .rst_n      (rst_n),
   .in_valid   (in_valid),
   .head_valid (head_valid),
   .grant      (grant),
   .out_valid  (out_valid)
);

`default_nettype wire

//--- dv/noc_router_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "noc_defs.svh"

module noc_router_tb;

   import noc_port_pkg::*;
   import noc_flit_pkg::*;

   // node under test sits at (1,2)
   localparam int X_SELF   = 1;
   localparam int Y_SELF   = 2;
   localparam int MAX_PK   = 6;
   localparam int WAIT_MAX = 200;

   logic                   clk;
   logic                   rst_n;
   logic [NUM_PORTS-1:0]   in_valid;
   logic [`NOC_FLIT_W-1:0] in_flit  [NUM_PORTS];
   logic [NUM_PORTS-1:0]   out_valid;
   logic [`NOC_FLIT_W-1:0] out_flit [NUM_PORTS];
   logic [NUM_PORTS-1:0]   overflow;

   // reference queues per output, due cycle -1 means any time
   logic [`NOC_FLIT_W-1:0] exp_flit [NUM_PORTS][$];
   int                     exp_cyc  [NUM_PORTS][$];

   int cyc    = 0;
   int errors = 0;
   int tests  = 0;
   int seed;

   noc_router #(
      .X_ADDR (X_SELF),
      .Y_ADDR (Y_SELF)
   ) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .out_valid (out_valid),
      .out_flit  (out_flit),
      .overflow  (overflow)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // rising edges so far
   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   ////////////////////
   // flit building
   ////////////////////

   // x first, then y, then local
   function automatic int xy_port(input int dx, input int dy);
      if (dx > X_SELF) return PORT_EAST;
      if (dx < X_SELF) return PORT_WEST;
      if (dy > Y_SELF) return PORT_SOUTH;
      if (dy < Y_SELF) return PORT_NORTH;
      return PORT_LOCAL;
   endfunction

   function automatic logic [`NOC_FLIT_W-1:0] hdr_flit(input int dx, input int dy);
      flit_u f;
      f            = '0;
      f.hdr.kind   = FLIT_HDR;
      f.hdr.dest_x = dx[`NOC_X_W-1:0];
      f.hdr.dest_y = dy[`NOC_Y_W-1:0];
      return f;
   endfunction

   function automatic logic [`NOC_FLIT_W-1:0] data_flit(input flit_kind_t kind,
                                                        input logic [5:0] pay);
      flit_u f;
      f.body.kind    = kind;
      f.body.payload = pay;
      return f;
   endfunction

   // header, bodies, tail with random payloads
   task automatic fill_packet(input int len, input int dx, input int dy,
                              output logic [`NOC_FLIT_W-1:0] pk [MAX_PK]);
      int rnd;
      for (int k = 0; k < MAX_PK; k++) begin
         rnd   = $random(seed);
         pk[k] = '0;
         if (k == 0) begin
            pk[k] = hdr_flit(dx, dy);
         end else if (k < len) begin
            pk[k] = data_flit((k == len - 1) ? FLIT_TAIL : FLIT_BODY, rnd[5:0]);
         end
      end
   endtask

   ////////////////////
   // drive and expect
   ////////////////////

   task automatic expect_flit(input int o, input logic [`NOC_FLIT_W-1:0] f, input int due);
      exp_flit[o].push_back(f);
      exp_cyc[o].push_back(due);
   endtask

   task automatic stage_flit(input int p, input logic [`NOC_FLIT_W-1:0] f);
      in_valid[p] = 1'b1;
      in_flit[p]  = f;
   endtask

   // strobes last one cycle
   task automatic step;
      @(negedge clk);
      in_valid = '0;
   endtask

   // lone packet, every flit due 2 cycles after its strobe
   task automatic send_alone(input int p, input logic [`NOC_FLIT_W-1:0] pk [MAX_PK],
                             input int len);
      flit_u h;
      int    o;
      h = pk[0];
      o = xy_port(h.hdr.dest_x, h.hdr.dest_y);
      for (int k = 0; k < len; k++) begin
         expect_flit(o, pk[k], cyc + 2);
         stage_flit(p, pk[k]);
         step;
      end
   endtask

   task automatic wait_drained(input string what);
      int n;
      int left;
      n    = 0;
      left = 1;
      while (left != 0 && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
         left = 0;
         for (int o = 0; o < NUM_PORTS; o++) begin
            left += exp_flit[o].size();
         end
      end
      if (left != 0) begin
         $display("timeout: %s still waits for %0d flits after %0d cycles",
                  what, left, WAIT_MAX);
         errors++;
         // stale flits would spoil the next test
         for (int o = 0; o < NUM_PORTS; o++) begin
            exp_flit[o].delete();
            exp_cyc[o].delete();
         end
      end
   endtask

   task automatic apply_reset;
      rst_n    = 1'b0;
      in_valid = '0;
      for (int o = 0; o < NUM_PORTS; o++) begin
         exp_flit[o].delete();
         exp_cyc[o].delete();
      end
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic check_bits(input string name, input logic [NUM_PORTS-1:0] got,
                             input logic [NUM_PORTS-1:0] want);
      a_bits: assert (got == want) else begin
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, want);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_start) ? "pass" : "fail");
   endtask

   ////////////////////
   // output monitor
   ////////////////////

   // registered outputs, stable on the falling edge
   always @(negedge clk) begin : monitor
      logic [`NOC_FLIT_W-1:0] want;
      int                     due;
      if (rst_n) begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            if (out_valid[o]) begin
               a_known: assert (exp_flit[o].size() != 0) else begin
                  $display("[ERROR] %0t out_valid[%0d] got 1 expected 0", $time, o);
                  errors++;
               end
               if (exp_flit[o].size() != 0) begin
                  want = exp_flit[o].pop_front();
                  due  = exp_cyc[o].pop_front();
                  a_flit: assert (out_flit[o] == want) else begin
                     $display("[ERROR] %0t out_flit[%0d] got %h expected %h",
                              $time, o, out_flit[o], want);
                     errors++;
                  end
                  a_due: assert (due < 0 || cyc == due) else begin
                     $display("[ERROR] %0t out_valid[%0d] cycle got %0d expected %0d",
                              $time, o, cyc, due);
                     errors++;
                  end
               end
            end
         end
      end
   end

   ////////////////////
   // tests
   ////////////////////

   initial begin
      int                     err0;
      int                     rnd;
      logic [NUM_PORTS-1:0]   ovf_want;
      logic [`NOC_FLIT_W-1:0] pk_a [MAX_PK];
      logic [`NOC_FLIT_W-1:0] pk_b [MAX_PK];
      seed     = 32'h5f86d576;
      rst_n    = 1'b0;
      in_valid = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         in_flit[p] = '0;
      end
      apply_reset;

      // quiet after reset
      err0 = errors;
      repeat (2) begin
         @(negedge clk);
         check_bits("out_valid", out_valid, '0);
         check_bits("overflow", overflow, '0);
      end
      report_test("reset", err0);

      // header plus tail from each input to each of the 16 nodes
      err0 = errors;
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int dy = 0; dy < `NOC_Y_NODES; dy++) begin
            for (int dx = 0; dx < `NOC_X_NODES; dx++) begin
               fill_packet(2, dx, dy, pk_a);
               send_alone(p, pk_a, 2);
               wait_drained("xy routing");
            end
         end
      end
      report_test("xy routing", err0);

      // 4-flit worm from west, random node
      err0 = errors;
      rnd  = $random(seed);
      fill_packet(4, rnd[1:0], rnd[3:2], pk_a);
      send_alone(PORT_WEST, pk_a, 4);
      wait_drained("wormhole");
      report_test("wormhole", err0);

      // east and south into local together
      // search starts at east after reset, south follows the whole east worm
      err0 = errors;
      apply_reset;
      fill_packet(3, X_SELF, Y_SELF, pk_a);
      fill_packet(3, X_SELF, Y_SELF, pk_b);
      for (int k = 0; k < 3; k++) begin
         expect_flit(PORT_LOCAL, pk_a[k], -1);
      end
      for (int k = 0; k < 3; k++) begin
         expect_flit(PORT_LOCAL, pk_b[k], -1);
      end
      for (int k = 0; k < 3; k++) begin
         stage_flit(PORT_EAST, pk_a[k]);
         stage_flit(PORT_SOUTH, pk_b[k]);
         step;
      end
      wait_drained("contention");
      report_test("contention", err0);

      // east and north 6-flit worms into local
      // north waits, keeps only what fits its buffer, drops the rest
      err0 = errors;
      apply_reset;
      fill_packet(6, X_SELF, Y_SELF, pk_a);
      fill_packet(6, X_SELF, Y_SELF, pk_b);
      for (int k = 0; k < 6; k++) begin
         expect_flit(PORT_LOCAL, pk_a[k], -1);
      end
      for (int k = 0; k < `NOC_BUF_DEPTH; k++) begin
         expect_flit(PORT_LOCAL, pk_b[k], -1);
      end
      for (int k = 0; k < 6; k++) begin
         stage_flit(PORT_EAST, pk_a[k]);
         stage_flit(PORT_NORTH, pk_b[k]);
         step;
      end
      wait_drained("overflow");
      ovf_want             = '0;
      ovf_want[PORT_NORTH] = 1'b1;
      check_bits("overflow", overflow, ovf_want);
      // still set later on
      repeat (3) @(negedge clk);
      check_bits("overflow", overflow, ovf_want);
      report_test("overflow", err0);

      $display("%0d tests, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- noc_router.f
+incdir+design
design/noc_flit_pkg.sv
design/noc_port_pkg.sv
design/noc_route_compute.sv
design/noc_input_port.sv
design/noc_output_arbiter.sv
design/noc_crossbar.sv
design/noc_router.sv
dv/noc_router_props.sv
dv/noc_router_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -j 0 \
   --top-module noc_router_tb -Mdir obj_dir -f noc_router.f &&
./obj_dir/Vnoc_router_tb | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
